//--- src/bp_pkg.sv
package bp_pkg;

    // ----------------------------------------------------------------------
    // Address type
    // ----------------------------------------------------------------------

    // Byte address of a fetch or a resolved branch
    // Instructions are one word wide, so bits [1:0] are always zero
    typedef logic [31:0] addr_t;

    // Distance between two sequential fetch addresses
    localparam addr_t WORD_STEP = 32'd4;

    // ----------------------------------------------------------------------
    // Direction counter
    // ----------------------------------------------------------------------

    // Two-bit saturating counter of the pattern table
    // Upper bit gives the predicted direction
    //   0x -> not taken
    //   1x -> taken
    // One step per resolved branch, towards the real outcome
    typedef enum logic [1:0] {
        // Several not-taken outcomes in a row
        STRONG_NT = 2'b00,
        // Reset state, one taken outcome flips it
        WEAK_NT   = 2'b01,
        // One not-taken outcome flips it
        WEAK_T    = 2'b10,
        // Several taken outcomes in a row
        STRONG_T  = 2'b11
    } counter_t;

    // Encoding follows a plain up and down count
    // Saturation holds the two ends, no wrap from 11 to 00
    // A single opposite outcome in a strong state keeps the prediction

endpackage

//--- src/gshare.sv
module gshare #(
    parameter int HISTORY_BITS = 8
) (
    input  logic                    clock,
    input  logic                    reset,

    // Fetch side
    input  bp_pkg::addr_t           if_pc_i,
    input  logic                    if_is_branch_i,

    // Execute side, one resolved branch per cycle
    input  logic                    ex_is_branch_i,
    input  logic                    ex_branch_taken_i,
    input  bp_pkg::addr_t           ex_branch_pc_i,
    input  logic [HISTORY_BITS-1:0] ex_history_i,
    input  logic                    mispredict_i,

    output logic                    predict_o,
    output logic [HISTORY_BITS-1:0] history_o
);

    // One counter per history pattern
    localparam int TABLE_SIZE = 2 ** HISTORY_BITS;

    // Pattern table and global history
    bp_pkg::counter_t          pht [TABLE_SIZE];
    logic [HISTORY_BITS-1:0]   global_history;
    logic [HISTORY_BITS-1:0]   next_history;

    // Table indices for the fetch lookup and the execute update
    logic [HISTORY_BITS-1:0]   if_index;
    logic [HISTORY_BITS-1:0]   ex_index;

    // Counter at the execute index and its trained value
    bp_pkg::counter_t          ex_state;
    bp_pkg::counter_t          ex_next_state;

    // ----------------------------------------------------------------------
    // Prediction
    // ----------------------------------------------------------------------

    // Word address bits only, the byte offset is always zero
    assign if_index  = if_pc_i[HISTORY_BITS+1:2] ^ global_history;

    // Upper counter bit is the direction
    assign predict_o = pht[if_index][1];

    // History used for this fetch travels with the instruction
    assign history_o = global_history;

    // ----------------------------------------------------------------------
    // History update
    // ----------------------------------------------------------------------

    always_comb begin
        // Hold by default, also while fetch is stalled
        next_history = global_history;

        // Speculative shift of the predicted direction
        if (if_is_branch_i) begin
            next_history = {global_history[HISTORY_BITS-2:0], predict_o};
        end

        // Recovery wins over the fetch shift
        // Carried history plus the real outcome
        if (ex_is_branch_i && mispredict_i) begin
            next_history = {ex_history_i[HISTORY_BITS-2:0], ex_branch_taken_i};
        end
    end

    // ----------------------------------------------------------------------
    // Counter training
    // ----------------------------------------------------------------------

    // Same hash as at fetch, with the history the branch was predicted with
    assign ex_index = ex_branch_pc_i[HISTORY_BITS+1:2] ^ ex_history_i;
    assign ex_state = pht[ex_index];

    // Saturating step towards the outcome
    always_comb begin
        ex_next_state = ex_state;
        case (ex_state)
            bp_pkg::STRONG_NT: begin
                ex_next_state = ex_branch_taken_i ? bp_pkg::WEAK_NT : bp_pkg::STRONG_NT;
            end
            bp_pkg::WEAK_NT: begin
                ex_next_state = ex_branch_taken_i ? bp_pkg::WEAK_T : bp_pkg::STRONG_NT;
            end
            bp_pkg::WEAK_T: begin
                ex_next_state = ex_branch_taken_i ? bp_pkg::STRONG_T : bp_pkg::WEAK_NT;
            end
            bp_pkg::STRONG_T: begin
                ex_next_state = ex_branch_taken_i ? bp_pkg::STRONG_T : bp_pkg::WEAK_T;
            end
            default: begin
                ex_next_state = bp_pkg::WEAK_NT;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // State registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            global_history <= '0;
            // All counters start weakly not taken
            for (int i = 0; i < TABLE_SIZE; i++) begin
                pht[i] <= bp_pkg::WEAK_NT;
            end
        end else begin
            global_history <= next_history;
            // Every resolved branch trains, mispredicted or not
            if (ex_is_branch_i) begin
                pht[ex_index] <= ex_next_state;
            end
        end
    end

endmodule

//--- src/branch_target_buffer.sv
module branch_target_buffer #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic          clock,
    input  logic          reset,

    // Lookup with the current fetch address
    input  bp_pkg::addr_t lookup_pc_i,

    // Write port from resolved taken branches
    input  logic          update_i,
    input  bp_pkg::addr_t update_pc_i,
    input  bp_pkg::addr_t update_target_i,

    output logic          hit_o,
    output bp_pkg::addr_t target_o
);

    // Address split
    //   [1:0]                 byte offset, always zero
    //   [INDEX_BITS+1:2]      entry index
    //   [31:INDEX_BITS+2]     tag
    localparam int INDEX_BITS = $clog2(BTB_ENTRIES);
    localparam int TAG_LSB    = INDEX_BITS + 2;
    localparam int TAG_BITS   = 32 - TAG_LSB;

    // Valid bits are control state and get cleared
    logic                  entry_valid  [BTB_ENTRIES];

    // Tags and targets only mean something once valid
    logic [TAG_BITS-1:0]   entry_tag    [BTB_ENTRIES];
    bp_pkg::addr_t         entry_target [BTB_ENTRIES];

    // Split fields of both addresses
    logic [INDEX_BITS-1:0] lookup_index;
    logic [TAG_BITS-1:0]   lookup_tag;
    logic [INDEX_BITS-1:0] update_index;
    logic [TAG_BITS-1:0]   update_tag;

    // ----------------------------------------------------------------------
    // Lookup
    // ----------------------------------------------------------------------

    // Word address modulo the table size
    assign lookup_index = lookup_pc_i[TAG_LSB-1:2];
    assign lookup_tag   = lookup_pc_i[31:TAG_LSB];

    // Hit needs a valid entry with the same upper address bits
    assign hit_o    = entry_valid[lookup_index] &&
                      (entry_tag[lookup_index] == lookup_tag);

    // Target read regardless of hit, the caller qualifies it
    assign target_o = entry_target[lookup_index];

    // ----------------------------------------------------------------------
    // Update
    // ----------------------------------------------------------------------

    assign update_index = update_pc_i[TAG_LSB-1:2];
    assign update_tag   = update_pc_i[31:TAG_LSB];

    // Valid bits
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                entry_valid[i] <= 1'b0;
            end
        end else if (update_i) begin
            entry_valid[update_index] <= 1'b1;
        end
    end

    // Tag and target payload
    // An aliasing branch simply replaces the older entry
    always_ff @(posedge clock) begin
        if (update_i) begin
            entry_tag[update_index]    <= update_tag;
            entry_target[update_index] <= update_target_i;
        end
    end

    // Write during lookup of the same entry shows up next cycle

endmodule

//--- src/fetch_pc_gen.sv
module fetch_pc_gen #(
    parameter bp_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  logic          clock,
    input  logic          reset,

    // Back-pressure from the fetch buffer
    input  logic          stall_i,

    // Prediction for the current fetch address
    input  logic          btb_hit_i,
    input  logic          predict_taken_i,
    input  bp_pkg::addr_t btb_target_i,

    // Recovery from execute
    input  logic          redirect_i,
    input  logic          redirect_taken_i,
    input  bp_pkg::addr_t redirect_pc_i,
    input  bp_pkg::addr_t redirect_target_i,

    output bp_pkg::addr_t fetch_pc_o
);

    // Fetch address register and its next value
    bp_pkg::addr_t pc_q;
    bp_pkg::addr_t pc_next;

    // Candidate addresses
    bp_pkg::addr_t seq_pc;
    bp_pkg::addr_t recover_pc;

    // ----------------------------------------------------------------------
    // Next address selection
    // ----------------------------------------------------------------------

    assign seq_pc = pc_q + bp_pkg::WORD_STEP;

    // Real path of the mispredicted branch
    assign recover_pc = redirect_taken_i ? redirect_target_i
                                         : redirect_pc_i + bp_pkg::WORD_STEP;

    always_comb begin
        // Recovery first, even while stalled
        if (redirect_i) begin
            pc_next = recover_pc;
        end else if (stall_i) begin
            pc_next = pc_q;
        end else if (btb_hit_i && predict_taken_i) begin
            // Predicted taken with a known target
            pc_next = btb_target_i;
        end else begin
            pc_next = seq_pc;
        end
    end

    // ----------------------------------------------------------------------
    // Fetch address register
    // ----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign fetch_pc_o = pc_q;

endmodule

//--- src/branch_predict_top.sv
module branch_predict_top #(
    parameter int            HISTORY_BITS = 8,
    parameter int            BTB_ENTRIES  = 16,
    parameter bp_pkg::addr_t RESET_PC     = 32'h0000_0000
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    stall_i,

    // Resolution report from execute
    input  logic                    ex_valid_i,
    input  bp_pkg::addr_t           ex_pc_i,
    input  bp_pkg::addr_t           ex_target_i,
    input  logic                    ex_taken_i,
    input  logic [HISTORY_BITS-1:0] ex_history_i,
    input  logic                    ex_mispredict_i,

    // Fetch request and its prediction
    output bp_pkg::addr_t           fetch_pc_o,
    output logic                    is_branch_o,
    output logic                    predict_taken_o,
    output logic [HISTORY_BITS-1:0] history_o
);

    bp_pkg::addr_t fetch_pc;
    logic          btb_hit;
    bp_pkg::addr_t btb_target;
    logic          direction;
    // Branch really fetched this cycle, history shifts only then
    logic          fetched_branch;

    assign fetched_branch = btb_hit & ~stall_i;

    // ----------------------------------------------------------------------
    // Fetch address
    // ----------------------------------------------------------------------

    fetch_pc_gen #(
        .RESET_PC          (RESET_PC)
    ) fetch_pc_gen_inst (
        .clock             (clock),
        .reset             (reset),
        .stall_i           (stall_i),
        .btb_hit_i         (btb_hit),
        .predict_taken_i   (direction),
        .btb_target_i      (btb_target),
        .redirect_i        (ex_valid_i & ex_mispredict_i),
        .redirect_taken_i  (ex_taken_i),
        .redirect_pc_i     (ex_pc_i),
        .redirect_target_i (ex_target_i),
        .fetch_pc_o        (fetch_pc)
    );

    // ----------------------------------------------------------------------
    // Predictors
    // ----------------------------------------------------------------------

    // Only taken branches get a target entry
    branch_target_buffer #(
        .BTB_ENTRIES     (BTB_ENTRIES)
    ) branch_target_buffer_inst (
        .clock           (clock),
        .reset           (reset),
        .lookup_pc_i     (fetch_pc),
        .update_i        (ex_valid_i & ex_taken_i),
        .update_pc_i     (ex_pc_i),
        .update_target_i (ex_target_i),
        .hit_o           (btb_hit),
        .target_o        (btb_target)
    );

    gshare #(
        .HISTORY_BITS      (HISTORY_BITS)
    ) gshare_inst (
        .clock             (clock),
        .reset             (reset),
        .if_pc_i           (fetch_pc),
        .if_is_branch_i    (fetched_branch),
        .ex_is_branch_i    (ex_valid_i),
        .ex_branch_taken_i (ex_taken_i),
        .ex_branch_pc_i    (ex_pc_i),
        .ex_history_i      (ex_history_i),
        .mispredict_i      (ex_mispredict_i),
        .predict_o         (direction),
        .history_o         (history_o)
    );

    assign fetch_pc_o      = fetch_pc;
    assign is_branch_o     = btb_hit;
    // A taken prediction always comes with a target
    assign predict_taken_o = direction & btb_hit;

endmodule

//--- sim/bp_clock_gen.sv
module bp_clock_gen #(
    // Half of the clock period in time units
    parameter int HALF_PERIOD = 2
) (
    output logic clock_o
);

    // Free running clock, starts low
    initial begin
        clock_o = 1'b0;
        forever begin
            #HALF_PERIOD clock_o = ~clock_o;
        end
    end

endmodule

//--- sim/bp_tb.sv
module bp_tb;

    // Same values as the DUT defaults
    localparam int            HISTORY_BITS = 8;
    localparam int            BTB_ENTRIES  = 16;
    localparam bp_pkg::addr_t RESET_PC     = 32'h0000_0000;
    localparam int            PHT_SIZE     = 2 ** HISTORY_BITS;

    logic                    clock;
    logic                    reset;
    logic                    stall_i;
    logic                    ex_valid_i;
    bp_pkg::addr_t           ex_pc_i;
    bp_pkg::addr_t           ex_target_i;
    logic                    ex_taken_i;
    logic [HISTORY_BITS-1:0] ex_history_i;
    logic                    ex_mispredict_i;
    bp_pkg::addr_t           fetch_pc_o;
    logic                    is_branch_o;
    logic                    predict_taken_o;
    logic [HISTORY_BITS-1:0] history_o;

    int     mismatch_count = 0;
    int     timeout_count  = 0;
    integer seed;
    string  test_name      = "reset";

    // Reference model state
    bp_pkg::addr_t           m_pc;
    logic [HISTORY_BITS-1:0] m_hist;
    bp_pkg::counter_t        m_pht        [PHT_SIZE];
    logic                    m_btb_valid  [BTB_ENTRIES];
    bp_pkg::addr_t           m_btb_tag    [BTB_ENTRIES];
    bp_pkg::addr_t           m_btb_target [BTB_ENTRIES];

    bp_clock_gen clock_gen_inst (
        .clock_o (clock)
    );

    branch_predict_top branch_predict_top_inst (
        .clock           (clock),
        .reset           (reset),
        .stall_i         (stall_i),
        .ex_valid_i      (ex_valid_i),
        .ex_pc_i         (ex_pc_i),
        .ex_target_i     (ex_target_i),
        .ex_taken_i      (ex_taken_i),
        .ex_history_i    (ex_history_i),
        .ex_mispredict_i (ex_mispredict_i),
        .fetch_pc_o      (fetch_pc_o),
        .is_branch_o     (is_branch_o),
        .predict_taken_o (predict_taken_o),
        .history_o       (history_o)
    );

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------

    task automatic check_addr(input string name, input bp_pkg::addr_t expected,
                              input bp_pkg::addr_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_history(input string name, input logic [HISTORY_BITS-1:0] expected,
                                 input logic [HISTORY_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------

    // Word address XOR history, low bits select the counter
    function automatic logic [HISTORY_BITS-1:0] pht_index(input bp_pkg::addr_t pc,
                                                         input logic [HISTORY_BITS-1:0] hist);
        bp_pkg::addr_t word;
        word = pc >> 2;
        return word[HISTORY_BITS-1:0] ^ hist;
    endfunction

    // Word address modulo the table size, the quotient is the tag
    function automatic int btb_index(input bp_pkg::addr_t pc);
        return int'((pc >> 2) % BTB_ENTRIES);
    endfunction

    function automatic bp_pkg::addr_t btb_tag(input bp_pkg::addr_t pc);
        return (pc >> 2) / BTB_ENTRIES;
    endfunction

    function automatic logic model_hit(input bp_pkg::addr_t pc);
        return m_btb_valid[btb_index(pc)] && (m_btb_tag[btb_index(pc)] == btb_tag(pc));
    endfunction

    function automatic logic model_dir(input bp_pkg::addr_t pc, input logic [HISTORY_BITS-1:0] hist);
        return m_pht[pht_index(pc, hist)] inside {bp_pkg::WEAK_T, bp_pkg::STRONG_T};
    endfunction

    // One count towards the outcome, held at both ends
    function automatic bp_pkg::counter_t saturate_step(input bp_pkg::counter_t state,
                                                       input logic taken);
        logic [1:0] count;
        count = state;
        if (taken && count != 2'b11) begin
            count = count + 2'd1;
        end else if (!taken && count != 2'b00) begin
            count = count - 2'd1;
        end
        return bp_pkg::counter_t'(count);
    endfunction

    // Next fetch address and history, packed as {pc, history}
    function automatic logic [HISTORY_BITS+31:0] reference_next(
        input logic stall, input logic valid, input logic taken, input logic misp,
        input bp_pkg::addr_t pc, input bp_pkg::addr_t target,
        input logic [HISTORY_BITS-1:0] hist);
        bp_pkg::addr_t           next_pc;
        logic [HISTORY_BITS-1:0] next_hist;
        logic                    hit;
        logic                    dir;
        hit = model_hit(m_pc);
        dir = model_dir(m_pc, m_hist);
        // Recovery first, then stall, then prediction
        if (valid && misp) begin
            next_pc = taken ? target : pc + bp_pkg::WORD_STEP;
        end else if (stall) begin
            next_pc = m_pc;
        end else if (hit && dir) begin
            next_pc = m_btb_target[btb_index(m_pc)];
        end else begin
            next_pc = m_pc + bp_pkg::WORD_STEP;
        end
        next_hist = m_hist;
        if (hit && !stall) begin
            next_hist = {m_hist[HISTORY_BITS-2:0], dir};
        end
        if (valid && misp) begin
            next_hist = {hist[HISTORY_BITS-2:0], taken};
        end
        return {next_pc, next_hist};
    endfunction

    task automatic reset_model();
        m_pc   = RESET_PC;
        m_hist = '0;
        for (int i = 0; i < PHT_SIZE; i++) begin
            m_pht[i] = bp_pkg::WEAK_NT;
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_btb_valid[i] = 1'b0;
        end
    endtask

    // Tables see every resolution, the BTB only taken ones
    task automatic train_model(input logic valid, input logic taken, input bp_pkg::addr_t pc,
                               input bp_pkg::addr_t target, input logic [HISTORY_BITS-1:0] hist);
        if (valid) begin
            m_pht[pht_index(pc, hist)] = saturate_step(m_pht[pht_index(pc, hist)], taken);
        end
        if (valid && taken) begin
            m_btb_valid[btb_index(pc)]  = 1'b1;
            m_btb_tag[btb_index(pc)]    = btb_tag(pc);
            m_btb_target[btb_index(pc)] = target;
        end
    endtask

    // Outputs still hold the values of the ending cycle at the rising edge
    always @(posedge clock) begin
        logic [HISTORY_BITS+31:0] next_state;
        if (reset) begin
            reset_model();
        end else begin
            check_addr({test_name, " fetch_pc"}, m_pc, fetch_pc_o);
            check_bit({test_name, " is_branch"}, model_hit(m_pc), is_branch_o);
            check_bit({test_name, " predict_taken"},
                      model_hit(m_pc) && model_dir(m_pc, m_hist), predict_taken_o);
            check_history({test_name, " history"}, m_hist, history_o);
            next_state = reference_next(stall_i, ex_valid_i, ex_taken_i, ex_mispredict_i,
                                        ex_pc_i, ex_target_i, ex_history_i);
            // Tables change after the prediction of this cycle
            train_model(ex_valid_i, ex_taken_i, ex_pc_i, ex_target_i, ex_history_i);
            m_pc   = next_state[HISTORY_BITS+31:HISTORY_BITS];
            m_hist = next_state[HISTORY_BITS-1:0];
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus helpers, all start and end on a falling edge
    // ----------------------------------------------------------------------

    task automatic clear_resolution();
        ex_valid_i      = 1'b0;
        ex_pc_i         = '0;
        ex_target_i     = '0;
        ex_taken_i      = 1'b0;
        ex_history_i    = '0;
        ex_mispredict_i = 1'b0;
    endtask

    // One resolved branch for one cycle
    task automatic resolve_branch(input bp_pkg::addr_t pc, input bp_pkg::addr_t target,
                                  input logic taken, input logic [HISTORY_BITS-1:0] hist,
                                  input logic misp);
        ex_valid_i      = 1'b1;
        ex_pc_i         = pc;
        ex_target_i     = target;
        ex_taken_i      = taken;
        ex_history_i    = hist;
        ex_mispredict_i = misp;
        @(negedge clock);
        clear_resolution();
    endtask

    // Not-taken mispredict just before addr, fetch resumes there with zero history
    task automatic redirect_to(input bp_pkg::addr_t addr);
        resolve_branch(addr - bp_pkg::WORD_STEP, 32'h0, 1'b0, '0, 1'b1);
    endtask

    task automatic wait_for_pc(input bp_pkg::addr_t addr, input int limit);
        int cycles;
        cycles = 0;
        while (fetch_pc_o !== addr && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (fetch_pc_o !== addr) begin
            $display("Timeout in %s: fetch address 0x%08h not reached within %0d cycles",
                     test_name, addr, limit);
            timeout_count++;
        end
    endtask

    // Train 0x1000 once, then fetch it with zero history and look at the direction
    task automatic train_and_probe(input logic taken, input logic expected, input string name);
        resolve_branch(32'h0000_1000, 32'h0000_2000, taken, '0, 1'b0);
        redirect_to(32'h0000_1000);
        check_addr({name, " fetch_pc"}, 32'h0000_1000, fetch_pc_o);
        check_bit({name, " predict_taken"}, expected, predict_taken_o);
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial begin
        bp_pkg::addr_t           held_pc;
        logic [HISTORY_BITS-1:0] held_hist;
        logic [31:0]             rnd;
        seed    = 11593;
        reset   = 1'b1;
        stall_i = 1'b0;
        clear_resolution();
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Reset state, then plain sequential fetch
        check_addr("reset fetch_pc", RESET_PC, fetch_pc_o);
        check_bit("reset is_branch", 1'b0, is_branch_o);
        check_bit("reset predict_taken", 1'b0, predict_taken_o);
        check_history("reset history", '0, history_o);
        repeat (5) @(negedge clock);
        check_addr("sequential fetch_pc", RESET_PC + 32'd20, fetch_pc_o);

        // BTB entry from a taken resolution under another history
        test_name = "training";
        resolve_branch(32'h0000_0040, 32'h0000_0100, 1'b1, 8'h55, 1'b0);
        wait_for_pc(32'h0000_0040, 40);
        check_bit("training first hit", 1'b1, is_branch_o);
        check_bit("training first direction", 1'b0, predict_taken_o);
        // Same history as at fetch, counter goes to weak taken
        resolve_branch(32'h0000_0040, 32'h0000_0100, 1'b1, 8'h00, 1'b0);
        redirect_to(32'h0000_0040);
        check_bit("training second hit", 1'b1, is_branch_o);
        check_bit("training second direction", 1'b1, predict_taken_o);
        @(negedge clock);
        check_addr("training jump", 32'h0000_0100, fetch_pc_o);
        check_history("training history shift", 8'h01, history_o);

        // Taken mispredict while the fetch buffer stalls
        test_name = "recovery";
        stall_i   = 1'b1;
        resolve_branch(32'h0000_0080, 32'h0000_0200, 1'b1, 8'hA3, 1'b1);
        check_addr("recovery fetch_pc", 32'h0000_0200, fetch_pc_o);
        check_history("recovery history", {7'h23, 1'b1}, history_o);

        // Stall stays on, a resolution trains both tables meanwhile
        // Address and history left by the recovery above
        test_name = "stall";
        held_pc   = 32'h0000_0200;
        held_hist = {7'h23, 1'b1};
        resolve_branch(32'h0000_0208, 32'h0000_0300, 1'b1, held_hist, 1'b0);
        for (int i = 0; i < 3; i++) begin
            check_addr("stall hold fetch_pc", held_pc, fetch_pc_o);
            check_history("stall hold history", held_hist, history_o);
            @(negedge clock);
        end
        stall_i = 1'b0;
        wait_for_pc(32'h0000_0208, 8);
        check_bit("stall trained hit", 1'b1, is_branch_o);
        check_bit("stall trained direction", 1'b1, predict_taken_o);
        @(negedge clock);
        check_addr("stall trained jump", 32'h0000_0300, fetch_pc_o);

        // Walk one counter to both ends and back
        test_name = "saturation";
        train_and_probe(1'b1, 1'b1, "sat weak taken");
        train_and_probe(1'b1, 1'b1, "sat strong taken");
        train_and_probe(1'b1, 1'b1, "sat taken held");
        train_and_probe(1'b0, 1'b1, "sat first not taken");
        train_and_probe(1'b0, 1'b0, "sat second not taken");
        train_and_probe(1'b0, 1'b0, "sat strong not taken");
        train_and_probe(1'b0, 1'b0, "sat not taken held");
        train_and_probe(1'b1, 1'b0, "sat first taken");
        train_and_probe(1'b1, 1'b1, "sat second taken");

        // Small address range, so both tables alias often
        test_name = "random";
        for (int i = 0; i < 400; i++) begin
            rnd             = $random(seed);
            stall_i         = (rnd[19:18] == 2'b00);
            ex_valid_i      = rnd[16];
            ex_pc_i         = {24'h0, rnd[5:0], 2'b00};
            ex_target_i     = {24'h0, rnd[11:6], 2'b00};
            ex_taken_i      = rnd[12];
            ex_mispredict_i = (rnd[15:14] == 2'b00);
            ex_history_i    = rnd[HISTORY_BITS+19:20];
            @(negedge clock);
        end
        stall_i = 1'b0;
        clear_resolution();
        repeat (2) @(negedge clock);

        $display("Error counts: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/bp_pkg.sv
src/gshare.sv
src/branch_target_buffer.sv
src/fetch_pc_gen.sv
src/branch_predict_top.sv
sim/bp_clock_gen.sv
sim/bp_tb.sv

//--- Makefile
# Verilator build and run of the branch predictor testbench
# All variables can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= bp_tb
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG_FILE  ?= sim.log
PASS_TEXT ?= Done: no errors
VFLAGS    ?= --binary --timing -j 0

SOURCES   := $(wildcard src/*.sv sim/*.sv)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG_FILE) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG_FILE)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG_FILE)
	@if grep -qF "$(PASS_TEXT)" $(LOG_FILE); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG_FILE)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)
